// File: rtl/core_settings.svh
// datapath, decode and BAR0 register map size defines
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// completer datapath, one dword per request
`define CORE_DATA_WIDTH 32
`define CORE_BE_WIDTH 4
`define CORE_TAG_WIDTH 8
`define CORE_BAR_WIDTH 3

// dword address covering a 24-bit byte aperture
`define CORE_ADDR_WIDTH 22

// BAR0 register map
`define CORE_BAR0_APERTURE 24
`define CORE_SCRATCH_COUNT 8
`define CORE_ID_VALUE 32'h5043_0001

`endif

// File: rtl/pcie_tlp_pkg.sv
// request and completion field types, request kinds and completion status codes
`include "core_settings.svh"

package pcie_tlp_pkg;

    // field widths of the simplified CQ/CC beats
    typedef logic [`CORE_BAR_WIDTH-1:0]  bar_t;
    typedef logic [`CORE_ADDR_WIDTH-1:0] dw_addr_t;
    typedef logic [`CORE_BE_WIDTH-1:0]   be_t;
    typedef logic [`CORE_TAG_WIDTH-1:0]  tag_t;
    typedef logic [`CORE_DATA_WIDTH-1:0] data_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } req_kind_e;

    // only the two codes this completer can return
    typedef enum logic [2:0] {
        CPL_SC = 3'd0,
        CPL_UR = 3'd1
    } cpl_status_e;

    // one CQ beat, 70 bits
    typedef struct packed {
        req_kind_e kind;
        bar_t      bar;
        dw_addr_t  dw_addr;
        be_t       first_be;
        tag_t      tag;
        data_t     data;
    } cq_req_t;

    // request after BAR and aperture decode
    typedef struct packed {
        cq_req_t req;
        logic    hit;
    } dec_req_t;

    // one CC beat, 43 bits
    typedef struct packed {
        tag_t        tag;
        cpl_status_e status;
        data_t       data;
    } cc_cpl_t;

endpackage

// File: rtl/core_regs_pkg.sv
// BAR0 register offsets, access kinds and the offset to access lookup
`include "core_settings.svh"

package core_regs_pkg;

    typedef enum logic [7:0] {
        REG_ID           = 8'd0,
        REG_WRITE_COUNT  = 8'd1,
        REG_SCRATCH_BASE = 8'd2
    } reg_offset_e;

    typedef enum logic {
        RO = 1'b0,
        RW = 1'b1
    } reg_access_e;

    // dwords in use; anything at or above this is unsupported
    localparam int REG_MAP_DWORDS = int'(REG_SCRATCH_BASE) + `CORE_SCRATCH_COUNT;

    // scratch registers are the only writable ones
    function automatic reg_access_e reg_access_of(logic [7:0] offset);
        reg_access_e access;
        access = RO;
        if (offset >= REG_SCRATCH_BASE && int'(offset) < REG_MAP_DWORDS) begin
            access = RW;
        end
        return access;
    endfunction

endpackage

// File: rtl/axis_if.sv
// valid/ready stream interface with a type-parameter payload and source/sink modports
`timescale 1ns/100ps

interface axis_if #(
    parameter type payload_t = logic
);

    logic     valid;
    logic     ready;
    payload_t payload;

    // transfer on a clock edge with valid and ready both high
    modport source (
        output valid,
        output payload,
        input  ready
    );

    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface

// File: rtl/cq_request_decoder.sv
// CQ request decoder with BAR and register map check, hit marking and the unsupported write error pulse
`timescale 1ns/100ps
`include "core_settings.svh"

module cq_request_decoder (
    input  logic  clk,
    input  logic  reset,
    axis_if.sink  cq,
    axis_if.source dec,
    output logic  status_error_uncor
);
    import pcie_tlp_pkg::*;
    import core_regs_pkg::*;

    logic     run_q;
    logic     dec_valid_q;
    dec_req_t dec_q;
    logic     err_q;

    logic accept;
    logic bar_hit;
    logic in_map;
    logic hit;
    logic is_write;

    // pass-through ready held low until the first cycle out of reset
    assign cq.ready = run_q && (!dec_valid_q || dec.ready);
    assign accept = cq.valid && cq.ready;

    assign bar_hit = cq.payload.bar == '0;
    assign in_map = int'(cq.payload.dw_addr) < REG_MAP_DWORDS;
    assign hit = bar_hit && in_map;
    assign is_write = cq.payload.kind == MEM_WRITE;

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q <= 1'b0;
            dec_valid_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            // posted write with nowhere to go
            err_q <= accept && is_write && !hit;
            if (accept) begin
                // unsupported writes die here and reads always go on for a UR
                dec_valid_q <= hit || !is_write;
            end else if (dec.ready) begin
                dec_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_q.req <= cq.payload;
            dec_q.hit <= hit;
        end
    end

    assign dec.valid = dec_valid_q;
    assign dec.payload = dec_q;
    assign status_error_uncor = err_q;

    // register file stall must not disturb the held request
    a_dec_hold: assert property (
        @(posedge clk) disable iff (reset)
        dec.valid && !dec.ready |=> dec.valid && $stable(dec.payload)
    );

endmodule

// File: rtl/bar_register_file.sv
// BAR0 register file: ID, write counter, byte-enabled scratch registers, read completions
`timescale 1ns/100ps
`include "core_settings.svh"

module bar_register_file (
    input  logic   clk,
    input  logic   reset,
    axis_if.sink   dec,
    axis_if.source cpl
);
    import pcie_tlp_pkg::*;
    import core_regs_pkg::*;

    localparam int DATA_W = `CORE_DATA_WIDTH;
    localparam int BE_W = `CORE_BE_WIDTH;
    localparam int IDX_W = $clog2(`CORE_SCRATCH_COUNT);

    logic [DATA_W-1:0] scratch [`CORE_SCRATCH_COUNT];
    logic [DATA_W-1:0] write_count;

    logic    cpl_valid_q;
    cc_cpl_t cpl_q;

    logic              accept;
    logic              is_write;
    logic [7:0]        offset;
    logic [7:0]        scratch_off;
    logic [IDX_W-1:0]  idx;
    logic [DATA_W-1:0] rd_data;
    logic [DATA_W-1:0] wr_merged;

    // stall while the completion register is full and not draining
    assign dec.ready = !cpl_valid_q || cpl.ready;
    assign accept = dec.valid && dec.ready;
    assign is_write = dec.payload.req.kind == MEM_WRITE;

    assign offset = dec.payload.req.dw_addr[7:0];
    assign scratch_off = offset - REG_SCRATCH_BASE;
    assign idx = scratch_off[IDX_W-1:0];

    // read mux, only meaningful when hit is set
    always_comb begin
        rd_data = '0;
        if (offset == REG_ID) begin
            rd_data = `CORE_ID_VALUE;
        end else if (offset == REG_WRITE_COUNT) begin
            rd_data = write_count;
        end else if (reg_access_of(offset) == RW) begin
            rd_data = scratch[idx];
        end
    end

    // byte lanes without an enable keep the old value
    always_comb begin
        for (int b = 0; b < BE_W; b++) begin
            wr_merged[b*8 +: 8] = dec.payload.req.first_be[b] ?
                dec.payload.req.data[b*8 +: 8] : scratch[idx][b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cpl_valid_q <= 1'b0;
            write_count <= '0;
            for (int i = 0; i < `CORE_SCRATCH_COUNT; i++) begin
                scratch[i] <= '0;
            end
        end else begin
            if (accept && is_write) begin
                // every BAR0 write counts, RO targets too
                write_count <= write_count + 1'b1;
                if (reg_access_of(offset) == RW) begin
                    scratch[idx] <= wr_merged;
                end
            end
            if (accept && !is_write) begin
                cpl_valid_q <= 1'b1;
            end else if (cpl.ready) begin
                cpl_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !is_write) begin
            cpl_q.tag <= dec.payload.req.tag;
            cpl_q.status <= dec.payload.hit ? CPL_SC : CPL_UR;
            cpl_q.data <= dec.payload.hit ? rd_data : '0;
        end
    end

    assign cpl.valid = cpl_valid_q;
    assign cpl.payload = cpl_q;

    // the decoder drops unsupported writes before they get here
    a_miss_is_read: assert property (
        @(posedge clk) disable iff (reset)
        dec.valid && !dec.payload.hit |-> dec.payload.req.kind == MEM_READ
    );

endmodule

// File: rtl/cc_completion_builder.sv
// CC completion builder: two-entry skid buffer with a registered output
`timescale 1ns/100ps

module cc_completion_builder #(
    parameter type payload_t = pcie_tlp_pkg::cc_cpl_t
) (
    input  logic   clk,
    input  logic   reset,
    axis_if.sink   cpl,
    axis_if.source cc
);

    logic     out_valid_q;
    payload_t out_q;
    logic     skid_valid_q;
    payload_t skid_q;

    logic [1:0] fill_level;
    logic       take;
    logic       drain;

    // skid only fills behind a stalled output, so the level is 0..2
    assign fill_level = {1'b0, out_valid_q} + {1'b0, skid_valid_q};

    // ready from fill level only, no path from cc.ready
    assign cpl.ready = fill_level < 2'd2;
    assign take = cpl.valid && cpl.ready;

    // output register can load this cycle
    assign drain = !out_valid_q || cc.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_q <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (drain) begin
            if (skid_valid_q) begin
                out_valid_q <= 1'b1;
                skid_valid_q <= 1'b0;
            end else begin
                out_valid_q <= take;
            end
        end else if (take) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (drain && (skid_valid_q || take)) begin
            // oldest entry first
            out_q <= skid_valid_q ? skid_q : cpl.payload;
        end
        if (!drain && take) begin
            skid_q <= cpl.payload;
        end
    end

    assign cc.valid = out_valid_q;
    assign cc.payload = out_q;

    a_cc_hold: assert property (
        @(posedge clk) disable iff (reset)
        cc.valid && !cc.ready |=> cc.valid && $stable(cc.payload)
    );

endmodule

// File: rtl/fpga_core.sv
// PCIe completer register core: plain CQ/CC ports over decoder, register file and builder
`timescale 1ns/100ps

module fpga_core (
    input  logic                       clk,
    input  logic                       reset,

    // completer request, one beat per request
    input  logic                       cq_valid,
    output logic                       cq_ready,
    input  pcie_tlp_pkg::req_kind_e    cq_kind,
    input  pcie_tlp_pkg::bar_t         cq_bar,
    input  pcie_tlp_pkg::dw_addr_t     cq_addr,
    input  pcie_tlp_pkg::be_t          cq_be,
    input  pcie_tlp_pkg::tag_t         cq_tag,
    input  pcie_tlp_pkg::data_t        cq_data,

    // completer completion
    output logic                       cc_valid,
    input  logic                       cc_ready,
    output pcie_tlp_pkg::tag_t         cc_tag,
    output pcie_tlp_pkg::cpl_status_e  cc_status,
    output pcie_tlp_pkg::data_t        cc_data,

    output logic                       status_error_uncor
);
    import pcie_tlp_pkg::*;

    axis_if #(.payload_t(cq_req_t))  cq_if ();
    axis_if #(.payload_t(dec_req_t)) dec_if ();
    axis_if #(.payload_t(cc_cpl_t))  cpl_if ();
    axis_if #(.payload_t(cc_cpl_t))  cc_if ();

    // CQ plain ports into the stream
    assign cq_if.valid = cq_valid;
    assign cq_if.payload = '{
        kind:     cq_kind,
        bar:      cq_bar,
        dw_addr:  cq_addr,
        first_be: cq_be,
        tag:      cq_tag,
        data:     cq_data
    };
    assign cq_ready = cq_if.ready;

    // CC stream out to plain ports
    assign cc_valid = cc_if.valid;
    assign cc_if.ready = cc_ready;
    assign cc_tag = cc_if.payload.tag;
    assign cc_status = cc_if.payload.status;
    assign cc_data = cc_if.payload.data;

    cq_request_decoder decoder_inst (
        .clk                (clk),
        .reset              (reset),
        .cq                 (cq_if),
        .dec                (dec_if),
        .status_error_uncor (status_error_uncor)
    );

    bar_register_file regfile_inst (
        .clk   (clk),
        .reset (reset),
        .dec   (dec_if),
        .cpl   (cpl_if)
    );

    cc_completion_builder #(
        .payload_t (cc_cpl_t)
    ) builder_inst (
        .clk   (clk),
        .reset (reset),
        .cpl   (cpl_if),
        .cc    (cc_if)
    );

endmodule

// File: dv/core_checker.sv
// completer core checker with register model, reference function and in-order compare
`timescale 1ns/100ps
`include "core_settings.svh"

module core_checker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cq_valid,
    input  logic                      cq_ready,
    input  pcie_tlp_pkg::req_kind_e   cq_kind,
    input  pcie_tlp_pkg::bar_t        cq_bar,
    input  pcie_tlp_pkg::dw_addr_t    cq_addr,
    input  pcie_tlp_pkg::be_t         cq_be,
    input  pcie_tlp_pkg::tag_t        cq_tag,
    input  pcie_tlp_pkg::data_t       cq_data,
    input  logic                      cc_valid,
    input  logic                      cc_ready,
    input  pcie_tlp_pkg::tag_t        cc_tag,
    input  pcie_tlp_pkg::cpl_status_e cc_status,
    input  pcie_tlp_pkg::data_t       cc_data,
    input  logic                      status_error_uncor,
    output int                        error_count,
    output int                        pending
);
    import pcie_tlp_pkg::*;

    // first dword past the scratch registers
    localparam int MAP_END = 2 + `CORE_SCRATCH_COUNT;
    localparam int IDX_W = $clog2(`CORE_SCRATCH_COUNT);

    data_t   model_scratch [`CORE_SCRATCH_COUNT];
    data_t   model_count;
    cc_cpl_t expected_q [$];
    logic    err_due;
    logic    reset_d1;
    logic    reset_d2;
    int      errors = 0;
    int      pending_q = 0;

    assign error_count = errors;
    assign pending = pending_q;

    // applies one request to the model and returns the completion a read of it must give
    function automatic cc_cpl_t ref_access(req_kind_e kind, bar_t bar, dw_addr_t addr,
                                           be_t be, tag_t tag, data_t data);
        cc_cpl_t          cpl;
        logic             hit;
        logic [IDX_W-1:0] idx;
        hit = (bar == '0) && (int'(addr) < MAP_END);
        idx = IDX_W'(addr - 22'd2);
        cpl.tag = tag;
        cpl.status = hit ? CPL_SC : CPL_UR;
        cpl.data = '0;
        if (hit && kind == MEM_WRITE) begin
            model_count = model_count + 32'd1;
            // only the scratch words take data
            if (addr >= 22'd2) begin
                for (int b = 0; b < `CORE_BE_WIDTH; b++) begin
                    if (be[b]) begin
                        model_scratch[idx][b*8 +: 8] = data[b*8 +: 8];
                    end
                end
            end
        end else if (hit) begin
            if (addr == 22'd0) begin
                cpl.data = `CORE_ID_VALUE;
            end else if (addr == 22'd1) begin
                cpl.data = model_count;
            end else begin
                cpl.data = model_scratch[idx];
            end
        end
        return cpl;
    endfunction

    task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] expected);
        $display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, expected);
        errors++;
    endtask

    always @(posedge clk) begin
        cc_cpl_t exp_cpl;
        reset_d1 <= reset;
        reset_d2 <= reset_d1;
        if (reset) begin
            model_count = '0;
            for (int i = 0; i < `CORE_SCRATCH_COUNT; i++) begin
                model_scratch[i] = '0;
            end
            expected_q.delete();
            err_due = 1'b0;
            if (reset_d1 && (cq_ready || cc_valid || status_error_uncor)) begin
                $display("[ERROR] %0t: outputs not low while reset is held", $time);
                errors++;
            end
        end else begin
            // cq_ready stays low for the first cycle out of reset and then rises
            if (reset_d1 && cq_ready) begin
                report_mismatch("cq_ready right after reset", 32'(cq_ready), 32'd0);
            end
            if (reset_d1 && cc_valid) begin
                report_mismatch("cc_valid right after reset", 32'(cc_valid), 32'd0);
            end
            if (!reset_d1 && reset_d2 && !cq_ready) begin
                report_mismatch("cq_ready one cycle after reset", 32'(cq_ready), 32'd1);
            end
            if (status_error_uncor !== err_due) begin
                report_mismatch("status_error_uncor", 32'(status_error_uncor), 32'(err_due));
            end
            err_due = 1'b0;
            if (cc_valid && cc_ready) begin
                if (expected_q.size() == 0) begin
                    $display("completion with tag %0h arrived with no read outstanding at %0t",
                             cc_tag, $time);
                    errors++;
                end else begin
                    exp_cpl = expected_q.pop_front();
                    if (cc_tag !== exp_cpl.tag) begin
                        report_mismatch("cc_tag", 32'(cc_tag), 32'(exp_cpl.tag));
                    end
                    if (cc_status !== exp_cpl.status) begin
                        report_mismatch("cc_status", 32'(cc_status), 32'(exp_cpl.status));
                    end
                    if (cc_data !== exp_cpl.data) begin
                        report_mismatch("cc_data", cc_data, exp_cpl.data);
                    end
                end
            end
            if (cq_valid && cq_ready) begin
                exp_cpl = ref_access(cq_kind, cq_bar, cq_addr, cq_be, cq_tag, cq_data);
                if (cq_kind == MEM_READ) begin
                    expected_q.push_back(exp_cpl);
                end else if (exp_cpl.status == CPL_UR) begin
                    // dropped posted write pulses the error on the next edge
                    err_due = 1'b1;
                end
            end
        end
        pending_q <= expected_q.size();
    end

endmodule

// File: dv/tb_fpga_core.sv
// testbench top: clock, reset, directed and random CQ traffic, random CC back-pressure
`timescale 1ns/100ps
`include "core_settings.svh"

module tb_fpga_core;
    import pcie_tlp_pkg::*;

    localparam int WAIT_LIMIT = 1000;
    localparam int RANDOM_REQS = 300;
    localparam int MAP_END = 2 + `CORE_SCRATCH_COUNT;

    logic        clk = 1'b0;
    logic        reset;
    logic        cq_valid;
    logic        cq_ready;
    req_kind_e   cq_kind;
    bar_t        cq_bar;
    dw_addr_t    cq_addr;
    be_t         cq_be;
    tag_t        cq_tag;
    data_t       cq_data;
    logic        cc_valid;
    logic        cc_ready = 1'b1;
    tag_t        cc_tag;
    cpl_status_e cc_status;
    data_t       cc_data;
    logic        status_error_uncor;

    logic random_ready = 1'b0;
    tag_t next_tag;
    int   error_count;
    int   pending;
    int   tb_errors;
    int   timeouts;

    always #5 clk = ~clk;

    // roughly one stall cycle in four during mixed traffic
    always @(posedge clk) begin
        if (random_ready) begin
            cc_ready <= $urandom_range(0, 3) != 0;
        end else begin
            cc_ready <= 1'b1;
        end
    end

    fpga_core DUT (
        .clk(clk), .reset(reset),
        .cq_valid(cq_valid), .cq_ready(cq_ready), .cq_kind(cq_kind), .cq_bar(cq_bar),
        .cq_addr(cq_addr), .cq_be(cq_be), .cq_tag(cq_tag), .cq_data(cq_data),
        .cc_valid(cc_valid), .cc_ready(cc_ready), .cc_tag(cc_tag), .cc_status(cc_status),
        .cc_data(cc_data), .status_error_uncor(status_error_uncor)
    );

    core_checker check_inst (
        .clk(clk), .reset(reset),
        .cq_valid(cq_valid), .cq_ready(cq_ready), .cq_kind(cq_kind), .cq_bar(cq_bar),
        .cq_addr(cq_addr), .cq_be(cq_be), .cq_tag(cq_tag), .cq_data(cq_data),
        .cc_valid(cc_valid), .cc_ready(cc_ready), .cc_tag(cc_tag), .cc_status(cc_status),
        .cc_data(cc_data), .status_error_uncor(status_error_uncor),
        .error_count(error_count), .pending(pending)
    );

    // called on a rising edge, returns on the edge that accepted the request
    task automatic send_req(req_kind_e kind, bar_t bar, dw_addr_t addr, be_t be, data_t data);
        int   n;
        logic taken;
        cq_valid <= 1'b1;
        cq_kind <= kind;
        cq_bar <= bar;
        cq_addr <= addr;
        cq_be <= be;
        cq_tag <= next_tag;
        cq_data <= data;
        next_tag = next_tag + 8'd1;
        n = 0;
        taken = 1'b0;
        while (!taken && n < WAIT_LIMIT) begin
            @(negedge clk);
            taken = cq_ready;
            @(posedge clk);
            n++;
        end
        cq_valid <= 1'b0;
        if (!taken) begin
            $display("timeout: request with tag %0h was never accepted", cq_tag);
            timeouts++;
        end
    endtask

    // read accepted on the last edge should transfer three edges later
    task automatic check_read_latency();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cc_valid && n < WAIT_LIMIT);
        if (!cc_valid) begin
            $display("timeout: no completion for the ID read");
            timeouts++;
        end else if (n != 3) begin
            $display("[ERROR] %0t: completion after %0d edges, expected 3", $time, n);
            tb_errors++;
        end
        @(posedge clk);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (pending != 0 && n < WAIT_LIMIT);
        if (pending != 0) begin
            $display("timeout: %0d read completions never arrived", pending);
            timeouts++;
        end
        @(posedge clk);
    endtask

    task automatic random_req();
        bar_t     bar;
        dw_addr_t addr;
        bar = ($urandom_range(0, 7) == 0) ? 3'd2 : 3'd0;
        addr = ($urandom_range(0, 15) == 0) ? 22'($urandom) : 22'($urandom_range(0, 11));
        send_req(req_kind_e'(1'($urandom_range(0, 1))), bar, addr, 4'($urandom), $urandom);
        if ($urandom_range(0, 4) == 0) begin
            @(posedge clk);
        end
    endtask

    initial begin
        void'($urandom(32'hb145d2ec));
        reset <= 1'b1;
        cq_valid <= 1'b0;
        cq_kind <= MEM_READ;
        cq_bar <= '0;
        cq_addr <= '0;
        cq_be <= '0;
        cq_tag <= '0;
        cq_data <= '0;
        next_tag = '0;
        tb_errors = 0;
        timeouts = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        send_req(MEM_READ, 3'd0, 22'd0, 4'hf, '0);
        check_read_latency();

        // two partial writes per scratch word, then read back the merge
        for (int i = 0; i < `CORE_SCRATCH_COUNT; i++) begin
            send_req(MEM_WRITE, 3'd0, 22'(2 + i), 4'($urandom), $urandom);
            send_req(MEM_WRITE, 3'd0, 22'(2 + i), 4'($urandom), $urandom);
            send_req(MEM_READ, 3'd0, 22'(2 + i), 4'hf, '0);
        end

        // ID is read only, the write still counts
        send_req(MEM_WRITE, 3'd0, 22'd0, 4'hf, 32'hdead_beef);
        send_req(MEM_READ, 3'd0, 22'd0, 4'hf, '0);
        send_req(MEM_READ, 3'd1, 22'd1, 4'hf, '0);
        send_req(MEM_READ, 3'd0, 22'd1, 4'hf, '0);

        // unsupported BAR and addresses past the map
        send_req(MEM_READ, 3'd2, 22'd3, 4'hf, '0);
        send_req(MEM_READ, 3'd0, 22'(MAP_END), 4'hf, '0);
        send_req(MEM_READ, 3'd0, 22'h3f_ffff, 4'hf, '0);
        send_req(MEM_WRITE, 3'd2, 22'd3, 4'hf, $urandom);
        send_req(MEM_WRITE, 3'd0, 22'(MAP_END), 4'hf, $urandom);
        send_req(MEM_READ, 3'd0, 22'd1, 4'hf, '0);
        send_req(MEM_READ, 3'd0, 22'd3, 4'hf, '0);
        wait_drain();

        random_ready <= 1'b1;
        for (int i = 0; i < RANDOM_REQS; i++) begin
            random_req();
        end
        random_ready <= 1'b0;
        wait_drain();
        repeat (4) @(posedge clk);

        $display("errors: checker %0d, testbench %0d, timeouts %0d",
                 error_count, tb_errors, timeouts);
        if (error_count == 0 && tb_errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+rtl
rtl/pcie_tlp_pkg.sv
rtl/core_regs_pkg.sv
rtl/axis_if.sv
rtl/cq_request_decoder.sv
rtl/bar_register_file.sv
rtl/cc_completion_builder.sv
rtl/fpga_core.sv
dv/core_checker.sv
dv/tb_fpga_core.sv

// File: Makefile
# Verilator lint and simulation of the completer core testbench

VERILATOR ?= verilator
TOP       ?= tb_fpga_core
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f project.f

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f project.f
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
